/* build.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_addr_check.sv
verilog/lsu_lane_format.sv
verilog/lsu_l15_ctrl.sv
verilog/lsu_top.sv
testbench/lsu_checker.sv
testbench/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_lsu -f build.f -o sim_lsu

./obj_dir/sim_lsu > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi

/* testbench/lsu_checker.sv */
// LSU checker
// watches the core and L1.5 ports, predicts every access from a
// reference memory and counts value and protocol errors
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_checker (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 req,
    input  logic                 ack,
    input  lsu_pkg::lsu_req_t    req_data,
    input  lsu_pkg::lsu_result_t result,
    input  lsu_pkg::l15_req_t    l15_req,
    input  logic                 l15_val,
    input  logic                 l15_ack,
    input  logic                 l15_header_ack,
    input  logic                 resp_val,
    input  logic                 resp_ack,
    output int                   value_errors,
    output int                   protocol_errors
);

    logic [7:0]             ref_mem [0:255];
    lsu_pkg::lsu_req_t      cur;        // access in flight
    logic [31:0]            exp_addr;
    logic [`LSU_SIZE_W-1:0] exp_size;
    logic                   exp_fault;
    logic                   saw_xfer;
    logic                   resp_open;
    logic                   resp_done;
    logic                   req_q;
    logic                   ack_q;
    logic                   val_q;
    logic                   xfer_q;
    logic                   resp_val_q;
    lsu_pkg::l15_req_t      l15_req_q;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
        value_errors++;
    endtask

    task automatic note_violation(input string what);
        $display("protocol error at %0t: %s", $time, what);
        protocol_errors++;
    endtask

    function automatic int width_of(input lsu_pkg::mem_op_e op);
        case (op[2:1])
            2'b11:   return 4;
            2'b01:   return 2;
            default: return 1;
        endcase
    endfunction

    // operand bytes laid out with the lowest address in the top byte
    function automatic logic [31:0] big_endian(input logic [31:0] v);
        logic [31:0] out;
        for (int i = 0; i < 4; i++) begin
            out[31 - 8*i -: 8] = v[8*i +: 8];
        end
        return out;
    endfunction

    function automatic logic [31:0] predict_load(input lsu_pkg::mem_op_e op,
                                                 input logic [7:0] a);
        logic [31:0] raw;
        raw = {ref_mem[a + 8'd3], ref_mem[a + 8'd2], ref_mem[a + 8'd1], ref_mem[a]};
        case (op)
            lsu_pkg::LB:  return {{24{raw[7]}}, raw[7:0]};
            lsu_pkg::LBU: return {24'b0, raw[7:0]};
            lsu_pkg::LH:  return {{16{raw[15]}}, raw[15:0]};
            lsu_pkg::LHU: return {16'b0, raw[15:0]};
            default:      return raw;
        endcase
    endfunction

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        exp_fault       = 1'b0;
        resp_open       = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'(i * 37 + 11);  // same fill as the responder
        end
    end

    always @(posedge clk) begin
        if (nrst) begin
            if (req && !req_q) begin
                cur       = req_data;
                exp_addr  = req_data.base + (req_data.op[3] ? req_data.s_imm : req_data.operand);
                exp_fault = (width_of(req_data.op) == 4 && exp_addr[1:0] != 2'b00) ||
                            (width_of(req_data.op) == 2 && exp_addr[0]);
                saw_xfer  = 1'b0;
                resp_done = 1'b0;
            end
            if (val_q && !xfer_q && (!l15_val || l15_req != l15_req_q)) begin
                note_violation("l15_val or l15_req changed while the request was stalled");
            end
            if (l15_val && exp_fault) begin
                note_violation("l15_val raised for a misaligned access");
            end
            if (l15_val && l15_ack && l15_header_ack) begin
                saw_xfer = 1'b1;
                if (l15_req.address != exp_addr) begin
                    report_mismatch("l15_req.address", exp_addr, l15_req.address);
                end
                if (cur.op[3]) begin
                    if (l15_req.rqtype != lsu_pkg::STORE_RQ) begin
                        report_mismatch("l15_req.rqtype", 32'(lsu_pkg::STORE_RQ),
                                        32'(l15_req.rqtype));
                    end
                    exp_size = (width_of(cur.op) == 4) ? `LSU_SIZE_4B :
                               (width_of(cur.op) == 2) ? `LSU_SIZE_2B : `LSU_SIZE_1B;
                    if (l15_req.size != exp_size) begin
                        report_mismatch("l15_req.size", 32'(exp_size), 32'(l15_req.size));
                    end
                    if (l15_req.data != big_endian(cur.operand)) begin
                        report_mismatch("l15_req.data", big_endian(cur.operand), l15_req.data);
                    end
                end else if (l15_req.rqtype != lsu_pkg::LOAD_RQ) begin
                    report_mismatch("l15_req.rqtype", 32'(lsu_pkg::LOAD_RQ), 32'(l15_req.rqtype));
                end
            end
            if (resp_val && !resp_val_q) begin
                if (resp_open) begin
                    note_violation("new response before the last one was acknowledged");
                end
                resp_open = 1'b1;
            end
            if (resp_ack) begin
                if (!resp_val || !resp_open) begin
                    note_violation("resp_ack without a pending response");
                end
                resp_open = 1'b0;
                resp_done = 1'b1;
            end
            if (ack && !ack_q) begin
                if (!req_q) begin
                    note_violation("ack rose while req was low");
                end
                if (exp_fault) begin
                    if (saw_xfer) begin
                        note_violation("misaligned access reached the L1.5 port");
                    end
                    if (result.ld_misaligned != !cur.op[3]) begin
                        report_mismatch("result.ld_misaligned", 32'(!cur.op[3]),
                                        32'(result.ld_misaligned));
                    end
                    if (result.st_misaligned != cur.op[3]) begin
                        report_mismatch("result.st_misaligned", 32'(cur.op[3]),
                                        32'(result.st_misaligned));
                    end
                end else begin
                    if (!saw_xfer || !resp_done) begin
                        note_violation("ack came before the L1.5 transfer and response");
                    end
                    if (result.ld_misaligned || result.st_misaligned) begin
                        report_mismatch("result.misaligned flags", 32'h0,
                                        {30'b0, result.ld_misaligned, result.st_misaligned});
                    end
                    if (cur.op[3]) begin
                        for (int i = 0; i < width_of(cur.op); i++) begin
                            ref_mem[exp_addr[7:0] + 8'(i)] = cur.operand[8*i +: 8];
                        end
                    end
                end
                if (result.load_data != ((exp_fault || cur.op[3]) ? 32'h0
                                         : predict_load(cur.op, exp_addr[7:0]))) begin
                    report_mismatch("result.load_data", (exp_fault || cur.op[3]) ? 32'h0
                                    : predict_load(cur.op, exp_addr[7:0]), result.load_data);
                end
            end
            if (ack_q && !ack && req_q) begin
                note_violation("ack fell while req was still high");
            end
        end
        req_q      = req;
        ack_q      = ack;
        val_q      = l15_val;
        xfer_q     = l15_val && l15_ack && l15_header_ack;
        resp_val_q = resp_val;
        l15_req_q  = l15_req;
    end

endmodule

`default_nettype wire

/* testbench/tb_lsu.sv */
// LSU testbench top
// random core accesses from an LCG against an L1.5 responder model,
// with a watchdog and one closing summary line
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module tb_lsu;

    localparam int          NUM_OPS      = 300;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'd38697;

    logic                 clk;
    logic                 nrst;
    logic                 req;
    logic                 ack;
    lsu_pkg::lsu_req_t    req_data;
    lsu_pkg::lsu_result_t result;
    lsu_pkg::l15_req_t    l15_req;
    logic                 l15_val;
    logic                 l15_ack;
    logic                 l15_header_ack;
    lsu_pkg::l15_resp_t   l15_resp;
    logic                 resp_val;
    logic                 resp_ack;
    int                   value_errors;
    int                   protocol_errors;
    logic [31:0]          core_seed;
    logic [31:0]          resp_seed;
    logic [7:0]           line_mem [0:255];  // responder memory, byte per address

    lsu_top dut (
        .clk            (clk),
        .nrst           (nrst),
        .req            (req),
        .ack            (ack),
        .req_data       (req_data),
        .result         (result),
        .l15_req        (l15_req),
        .l15_val        (l15_val),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .l15_resp       (l15_resp),
        .resp_val       (resp_val),
        .resp_ack       (resp_ack)
    );

    lsu_checker u_checker (
        .clk             (clk),
        .nrst            (nrst),
        .req             (req),
        .ack             (ack),
        .req_data        (req_data),
        .result          (result),
        .l15_req         (l15_req),
        .l15_val         (l15_val),
        .l15_ack         (l15_ack),
        .l15_header_ack  (l15_header_ack),
        .resp_val        (resp_val),
        .resp_ack        (resp_ack),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    // one LCG step returning the upper half of the state
    function automatic logic [15:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[31:16];
    endfunction

    function automatic lsu_pkg::mem_op_e pick_op(input logic [2:0] k);
        case (k)
            3'd0:    return lsu_pkg::SW;
            3'd1:    return lsu_pkg::SH;
            3'd2:    return lsu_pkg::SB;
            3'd3:    return lsu_pkg::LW;
            3'd4:    return lsu_pkg::LH;
            3'd5:    return lsu_pkg::LHU;
            3'd6:    return lsu_pkg::LB;
            default: return lsu_pkg::LBU;
        endcase
    endfunction

    // one full four-phase exchange on the core side
    task automatic run_access(input lsu_pkg::lsu_req_t r);
        @(posedge clk);
        req_data <= r;
        req      <= 1'b1;
        do @(posedge clk); while (!ack);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : stimulus
        lsu_pkg::lsu_req_t r;
        logic [15:0]       rnd;
        logic [31:0]       addr;
        logic [31:0]       last_st_addr;
        logic              last_st;
        req          = 1'b0;
        req_data     = '0;
        nrst         = 1'b0;
        core_seed    = SEED;
        last_st      = 1'b0;
        last_st_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            rnd  = lcg_next(core_seed);
            r.op = pick_op(rnd[2:0]);
            rnd  = lcg_next(core_seed);
            addr = {24'b0, rnd[7:0]};  // 256-byte window
            if (last_st && !r.op[3] && rnd[12:11] == 2'b00) begin
                addr = last_st_addr;  // load back what was just stored
            end
            if (rnd[10:8] != 3'b000) begin
                if (r.op[2:1] == 2'b11) begin
                    addr[1:0] = 2'b00;
                end else if (r.op[2:1] == 2'b01) begin
                    addr[0] = 1'b0;
                end
            end
            r.base = {lcg_next(core_seed), lcg_next(core_seed)};
            if (r.op[3]) begin
                r.s_imm   = addr - r.base;
                r.operand = {lcg_next(core_seed), lcg_next(core_seed)};
            end else begin
                r.operand = addr - r.base;
                r.s_imm   = {lcg_next(core_seed), lcg_next(core_seed)};
            end
            last_st = r.op[3];
            if (r.op[3]) begin
                last_st_addr = addr;
            end
            run_access(r);
            repeat (int'(rnd[14:13])) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("summary: %0d value errors, %0d protocol errors in %0d accesses",
                 value_errors, protocol_errors, NUM_OPS);
        if (value_errors + protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // L1.5 model that stalls the header, applies stores and returns lines
    initial begin : responder
        lsu_pkg::l15_req_t  rq;
        lsu_pkg::l15_resp_t rsp;
        logic [15:0]        rnd;
        int                 nbytes;
        int                 stall;
        l15_ack        = 1'b0;
        l15_header_ack = 1'b0;
        resp_val       = 1'b0;
        l15_resp       = '0;
        resp_seed      = SEED;
        for (int i = 0; i < 256; i++) begin
            line_mem[i] = 8'(i * 37 + 11);
        end
        @(posedge nrst);
        forever begin
            do @(posedge clk); while (!l15_val);
            rnd   = lcg_next(resp_seed);
            stall = int'(rnd[7:0]) % 6;
            for (int d = 0; d < stall; d++) begin
                rnd = lcg_next(resp_seed);
                l15_ack        <= (rnd[1:0] == 2'd1);  // never both during a stall
                l15_header_ack <= (rnd[1:0] == 2'd2);
                @(posedge clk);
            end
            l15_ack        <= 1'b1;
            l15_header_ack <= 1'b1;
            @(posedge clk);
            rq = l15_req;  // transfer edge
            l15_ack        <= 1'b0;
            l15_header_ack <= 1'b0;
            rsp = '0;
            if (rq.rqtype == lsu_pkg::STORE_RQ) begin
                nbytes = (rq.size == `LSU_SIZE_4B) ? 4 : (rq.size == `LSU_SIZE_2B) ? 2 : 1;
                for (int i = 0; i < nbytes; i++) begin
                    line_mem[rq.address[7:0] + 8'(i)] = rq.data[31 - 8*i -: 8];
                end
                rsp.rettype = lsu_pkg::ST_ACK;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    rsp.data_0[63 - 8*i -: 8] = line_mem[{rq.address[7:4], 4'h0} + 8'(i)];
                    rsp.data_1[63 - 8*i -: 8] = line_mem[{rq.address[7:4], 4'h8} + 8'(i)];
                end
                rsp.rettype = lsu_pkg::LOAD_RET;
            end
            rnd = lcg_next(resp_seed);
            repeat (int'(rnd[7:0]) % 6) @(posedge clk);
            l15_resp <= rsp;
            resp_val <= 1'b1;
            do @(posedge clk); while (!resp_ack);
            resp_val <= 1'b0;
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_OPS * 40) @(posedge clk);
        $display("timeout: accesses did not complete within %0d cycles", NUM_OPS * 40);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/lsu_addr_check.sv */
// LSU address checker
// forms the effective address of a captured request and flags
// misaligned half and word accesses
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_addr_check (
    input  logic                clk,
    input  logic                nrst,
    input  logic                capture,
    input  lsu_pkg::lsu_req_t   req_in,
    output lsu_pkg::addr_info_t info
);

    lsu_pkg::lsu_req_t    req_q;
    logic [`LSU_XLEN-1:0] eff_addr;
    logic                 mis_half;
    logic                 mis_word;
    logic                 misaligned;
    logic                 is_load;
    logic                 is_store;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            req_q <= '0;
        end else if (capture) begin
            req_q <= req_in;
        end
    end

    // stores use s_imm, loads use the operand as offset
    assign eff_addr = req_q.op[3] ? req_q.base + req_q.s_imm
                                  : req_q.base + req_q.operand;

    assign mis_half   = req_q.op[1] & eff_addr[0];                // half and word
    assign mis_word   = req_q.op[1] & req_q.op[2] & eff_addr[1];  // word only
    assign misaligned = mis_half | mis_word;

    // misaligned ops never go to the cache
    assign is_load  = (req_q.op != lsu_pkg::NONE) & ~req_q.op[3] & ~misaligned;
    assign is_store = req_q.op[3] & ~misaligned;

    assign info = '{
        addr:       eff_addr,
        op:         req_q.op,
        misaligned: misaligned,
        is_load:    is_load,
        is_store:   is_store
    };

    // a captured op is a known load, store or no-op
    a_op_legal: assert property (@(posedge clk) disable iff (!nrst)
        capture |-> req_in.op inside {lsu_pkg::NONE, lsu_pkg::SW, lsu_pkg::SH,
                                      lsu_pkg::SB, lsu_pkg::LW, lsu_pkg::LH,
                                      lsu_pkg::LHU, lsu_pkg::LB, lsu_pkg::LBU});

endmodule

`default_nettype wire

/* verilog/lsu_l15_ctrl.sv */
// LSU L1.5 request controller
// runs the core four-phase handshake and the L1.5 val/ack exchange,
// then extracts and extends load data from the response line
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_l15_ctrl (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 req,
    output logic                 ack,
    output logic                 capture,
    input  lsu_pkg::addr_info_t  info,
    input  lsu_pkg::lane_info_t  lanes,
    output lsu_pkg::l15_req_t    l15_req,
    output logic                 l15_val,
    input  logic                 l15_ack,
    input  logic                 l15_header_ack,
    input  lsu_pkg::l15_resp_t   resp,
    input  logic                 resp_val,
    output logic                 resp_ack,
    output lsu_pkg::lsu_result_t result
);

    lsu_pkg::ctrl_state_e state;
    logic                 issue;
    logic                 xfer;
    logic                 resp_match;
    logic [`LSU_XLEN-1:0] word_be;
    logic [`LSU_XLEN-1:0] word_le;
    logic [7:0]           ld_byte;
    logic [15:0]          ld_half;
    logic [`LSU_XLEN-1:0] ld_value;

    assign capture  = (state == lsu_pkg::S_WAIT_REQ) && req;  // new request
    assign issue    = info.is_load || info.is_store;
    assign xfer     = l15_val && l15_ack && l15_header_ack;
    assign resp_ack = (state == lsu_pkg::S_WAIT_RESP) && resp_val;

    // other return types are acked and dropped
    assign resp_match =
        ((l15_req.rqtype == lsu_pkg::LOAD_RQ)  && (resp.rettype == lsu_pkg::LOAD_RET)) ||
        ((l15_req.rqtype == lsu_pkg::STORE_RQ) && (resp.rettype == lsu_pkg::ST_ACK));

    always_comb begin
        case (info.addr[3:2])
            2'b00:   word_be = resp.data_0[`LSU_LINE_W-1:`LSU_XLEN];
            2'b01:   word_be = resp.data_0[`LSU_XLEN-1:0];
            2'b10:   word_be = resp.data_1[`LSU_LINE_W-1:`LSU_XLEN];
            default: word_be = resp.data_1[`LSU_XLEN-1:0];
        endcase
    end

    assign word_le = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};
    assign ld_byte = word_le[{info.addr[1:0], 3'b000} +: 8];
    assign ld_half = word_le[{info.addr[1], 4'b0000} +: 16];

    always_comb begin
        case (info.op)
            lsu_pkg::LB:  ld_value = {{24{ld_byte[7]}}, ld_byte};
            lsu_pkg::LBU: ld_value = {24'b0, ld_byte};
            lsu_pkg::LH:  ld_value = {{16{ld_half[15]}}, ld_half};
            lsu_pkg::LHU: ld_value = {16'b0, ld_half};
            lsu_pkg::LW:  ld_value = word_le;
            default:      ld_value = '0;  // stores return nothing
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state   <= lsu_pkg::S_WAIT_REQ;
            ack     <= 1'b0;
            l15_val <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::S_WAIT_REQ: if (req) state <= lsu_pkg::S_ISSUE;
                lsu_pkg::S_ISSUE: begin
                    if (!issue) begin
                        ack   <= 1'b1;  // fault or no-op, finish now
                        state <= lsu_pkg::S_DONE;
                    end else if (!l15_val) begin
                        l15_val <= 1'b1;
                    end else if (xfer) begin
                        l15_val <= 1'b0;
                        state   <= lsu_pkg::S_WAIT_RESP;
                    end
                end
                lsu_pkg::S_WAIT_RESP: begin
                    if (resp_val && resp_match) begin
                        ack   <= 1'b1;
                        state <= lsu_pkg::S_DONE;
                    end
                end
                lsu_pkg::S_DONE, lsu_pkg::S_RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= lsu_pkg::S_WAIT_REQ;
                    end else begin
                        state <= lsu_pkg::S_RELEASE;  // core still holds req
                    end
                end
                default: state <= lsu_pkg::S_WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lsu_pkg::S_ISSUE && issue && !l15_val) begin
            l15_req.rqtype  <= info.is_store ? lsu_pkg::STORE_RQ : lsu_pkg::LOAD_RQ;
            l15_req.size    <= lanes.size;
            l15_req.address <= info.addr;
            l15_req.data    <= info.is_store ? lanes.data : '0;
        end
        if (state == lsu_pkg::S_ISSUE && !issue) begin
            result.load_data     <= '0;
            result.ld_misaligned <= info.misaligned & ~info.op[3];
            result.st_misaligned <= info.misaligned & info.op[3];
        end else if (resp_ack && resp_match) begin
            result.load_data     <= ld_value;
            result.ld_misaligned <= 1'b0;
            result.st_misaligned <= 1'b0;
        end
    end

    a_val_hold: assert property (@(posedge clk) disable iff (!nrst)
        l15_val && !(l15_ack && l15_header_ack) |=> l15_val && $stable(l15_req));

    a_ack_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

/* verilog/lsu_lane_format.sv */
// LSU lane formatter
// byte enables, L1.5 size code and big-endian store data
// for the captured request
`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsu_lane_format (
    input  logic                clk,
    input  logic                nrst,
    input  logic                capture,
    input  lsu_pkg::lsu_req_t   req_in,
    output lsu_pkg::lane_info_t lanes
);

    lsu_pkg::lsu_req_t      req_q;
    logic [`LSU_XLEN-1:0]   eff_addr;
    logic                   misaligned;
    logic                   is_store;
    logic [3:0]             byte_en;
    logic [`LSU_SIZE_W-1:0] size_code;
    logic [`LSU_XLEN-1:0]   swapped;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            req_q <= '0;
        end else if (capture) begin
            req_q <= req_in;
        end
    end

    // own copy of the address, kept local to this block
    assign eff_addr   = req_q.op[3] ? req_q.base + req_q.s_imm
                                    : req_q.base + req_q.operand;
    assign misaligned = (req_q.op[1] & eff_addr[0]) |
                        (req_q.op[1] & req_q.op[2] & eff_addr[1]);
    assign is_store   = req_q.op[3] & ~misaligned;

    always_comb begin
        byte_en = 4'b0000;  // loads and faults write nothing
        if (is_store) begin
            case (req_q.op[2:1])
                2'b11:   byte_en = 4'b1111;
                2'b01:   byte_en = eff_addr[1] ? 4'b1100 : 4'b0011;
                2'b10:   byte_en = 4'b0001 << eff_addr[1:0];
                default: byte_en = 4'b0000;
            endcase
        end
    end

    always_comb begin
        case (byte_en)
            4'b0011, 4'b1100:                   size_code = `LSU_SIZE_2B;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: size_code = `LSU_SIZE_1B;
            default:                            size_code = `LSU_SIZE_4B;  // word, loads
        endcase
    end

    assign swapped = {req_q.operand[7:0], req_q.operand[15:8],
                      req_q.operand[23:16], req_q.operand[31:24]};

    assign lanes = '{byte_en: byte_en, size: size_code, data: swapped};

    a_store_lanes: assert property (@(posedge clk) disable iff (!nrst)
        $past(capture) && is_store |-> lanes.byte_en inside
            {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111});

endmodule

`default_nettype wire

/* verilog/lsu_macros.svh */
// LSU shared widths and L1.5 message size codes
// fixed by the RV32 data path and the L1.5 port format
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN     32

// one half of the returned cache line
`define LSU_LINE_W   64

// L1.5 size field
`define LSU_SIZE_W   3

// size codes on the request header
`define LSU_SIZE_1B  3'b001
`define LSU_SIZE_2B  3'b010
`define LSU_SIZE_4B  3'b011

`endif

/* verilog/lsu_pkg.sv */
// LSU types: memory opcodes, L1.5 message codes, controller states
// and the structs passed between the memory stage blocks
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // bit 3 store, bits 2..1 width (11 word, 01 half, 10 byte), bit 0 signed
    typedef enum logic [3:0] {
        NONE = 4'b0000,
        SW   = 4'b1111,
        SH   = 4'b1011,
        SB   = 4'b1101,
        LW   = 4'b0111,
        LH   = 4'b0011,
        LHU  = 4'b0010,
        LB   = 4'b0101,
        LBU  = 4'b0100
    } mem_op_e;

    typedef enum logic [3:0] {
        LOAD_RQ  = 4'b0000,
        STORE_RQ = 4'b0001
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        LOAD_RET = 4'b0000,
        ST_ACK   = 4'b0100
    } l15_rettype_e;

    typedef enum logic [2:0] {
        S_WAIT_REQ,
        S_ISSUE,
        S_WAIT_RESP,
        S_DONE,
        S_RELEASE
    } ctrl_state_e;

    typedef struct packed {
        mem_op_e              op;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] operand;  // store data, or load offset
        logic [`LSU_XLEN-1:0] s_imm;
    } lsu_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
        mem_op_e              op;
        logic                 misaligned;
        logic                 is_load;
        logic                 is_store;
    } addr_info_t;

    typedef struct packed {
        logic [3:0]             byte_en;
        logic [`LSU_SIZE_W-1:0] size;
        logic [`LSU_XLEN-1:0]   data;   // big-endian store data
    } lane_info_t;

    typedef struct packed {
        l15_rqtype_e            rqtype;
        logic [`LSU_SIZE_W-1:0] size;
        logic [`LSU_XLEN-1:0]   address;
        logic [`LSU_XLEN-1:0]   data;
    } l15_req_t;

    typedef struct packed {
        l15_rettype_e           rettype;
        logic [`LSU_LINE_W-1:0] data_0;
        logic [`LSU_LINE_W-1:0] data_1;
    } l15_resp_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] load_data;
        logic                 ld_misaligned;
        logic                 st_misaligned;
    } lsu_result_t;

endpackage

`default_nettype wire

/* verilog/lsu_top.sv */
// LSU memory stage top
// address checker and lane formatter feed the L1.5 request controller
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 req,
    output logic                 ack,
    input  lsu_pkg::lsu_req_t    req_data,
    output lsu_pkg::lsu_result_t result,
    output lsu_pkg::l15_req_t    l15_req,
    output logic                 l15_val,
    input  logic                 l15_ack,
    input  logic                 l15_header_ack,
    input  lsu_pkg::l15_resp_t   l15_resp,
    input  logic                 resp_val,
    output logic                 resp_ack
);

    logic                capture;
    lsu_pkg::addr_info_t info;
    lsu_pkg::lane_info_t lanes;

    lsu_addr_check u_addr_check (
        .clk     (clk),
        .nrst    (nrst),
        .capture (capture),
        .req_in  (req_data),
        .info    (info)
    );

    lsu_lane_format u_lane_format (
        .clk     (clk),
        .nrst    (nrst),
        .capture (capture),
        .req_in  (req_data),
        .lanes   (lanes)
    );

    lsu_l15_ctrl u_ctrl (
        .clk            (clk),
        .nrst           (nrst),
        .req            (req),
        .ack            (ack),
        .capture        (capture),
        .info           (info),
        .lanes          (lanes),
        .l15_req        (l15_req),
        .l15_val        (l15_val),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .resp           (l15_resp),
        .resp_val       (resp_val),
        .resp_ack       (resp_ack),
        .result         (result)
    );

endmodule

`default_nettype wire
